//--- Makefile
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module cnn_cmd_tb -Mdir $(OBJ_DIR) -o cnn_cmd_sim

run: compile
	./$(OBJ_DIR)/cnn_cmd_sim | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/cmd_fifo.sv
`timescale 1ns/10ps

module cmd_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 i_wr_en,
    input  logic [cnn_cmd_pkg::CMD_WORD_W-1:0]   i_wr_data,
    input  logic                                 i_rd_en,
    output logic [cnn_cmd_pkg::CMD_WORD_W-1:0]   o_rd_data,
    output logic                                 o_full,
    output logic                                 o_empty
);

    import cnn_cmd_pkg::*;

    // Pointers wrap on their own for a power-of-two depth
    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [CMD_WORD_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    // One extra bit to tell full from empty
    logic [PTR_W:0]        count;
    logic                  do_wr;
    logic                  do_rd;

    assign do_wr = i_wr_en && !o_full;
    assign do_rd = i_rd_en && !o_empty;

    // Storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_data;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Show-ahead, head word visible without a read
    assign o_rd_data = mem[rd_ptr];
    assign o_full    = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign o_empty   = (count == '0);

    // Writer must respect the full flag
    a_wr_not_full: assert property (
        @(posedge clk) disable iff (rst)
        i_wr_en |-> !o_full
    );

    // Reader must respect the empty flag
    a_rd_not_empty: assert property (
        @(posedge clk) disable iff (rst)
        i_rd_en |-> !o_empty
    );

endmodule

//--- design/cmd_loader.sv
`timescale 1ns/10ps

module cmd_loader #(
    parameter int MEM_ADDR_W = 8
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 i_op_en,
    input  logic [cnn_cmd_pkg::CMD_CNT_W-1:0]    i_cmd_count,
    input  logic                                 i_fifo_full,
    input  logic [cnn_cmd_pkg::CMD_WORD_W-1:0]   i_mem_rd_data,
    output logic                                 o_mem_rd_en,
    output logic [MEM_ADDR_W-1:0]                o_mem_addr,
    output logic                                 o_fifo_wr_en,
    output logic [cnn_cmd_pkg::CMD_WORD_W-1:0]   o_fifo_wr_data
);

    import cnn_cmd_pkg::*;

    // Words to fetch for the whole run
    logic [WORD_CNT_W-1:0] fetch_total;
    // Reads issued so far
    logic [WORD_CNT_W-1:0] fetch_cnt;
    // Memory word arriving this cycle
    logic                  rsp_valid;
    logic                  fetch_done;
    logic                  can_issue;

    assign fetch_total = WORD_CNT_W'(i_cmd_count) * WORD_CNT_W'(CMD_WORDS);
    assign fetch_done  = (fetch_cnt == fetch_total);

    // At most one read in flight
    // No new read while one is issued or its word is still arriving
    // Room in the FIFO is known here since only this block writes it
    assign can_issue = i_op_en && !fetch_done && !o_mem_rd_en && !rsp_valid && !i_fifo_full;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_mem_rd_en <= 1'b0;
            o_mem_addr  <= '0;
            fetch_cnt   <= '0;
            rsp_valid   <= 1'b0;
        end else if (!i_op_en) begin
            // Run dropped, restart from address 0 next time
            o_mem_rd_en <= 1'b0;
            o_mem_addr  <= '0;
            fetch_cnt   <= '0;
            rsp_valid   <= 1'b0;
        end else begin
            // Read strobe lasts one cycle
            o_mem_rd_en <= can_issue;
            // Memory answers one cycle after the strobe
            rsp_valid   <= o_mem_rd_en;
            if (can_issue) begin
                fetch_cnt <= fetch_cnt + 1'b1;
            end
            // Step the address once the read has been taken
            if (o_mem_rd_en) begin
                o_mem_addr <= o_mem_addr + 1'b1;
            end
        end
    end

    // Returned word goes straight into the FIFO
    assign o_fifo_wr_en   = rsp_valid;
    assign o_fifo_wr_data = i_mem_rd_data;

    // Full flag sampled at issue time must still hold when the word lands
    a_no_wr_when_full: assert property (
        @(posedge clk) disable iff (rst)
        o_fifo_wr_en |-> !i_fifo_full
    );

endmodule

//--- design/cmd_sequencer.sv
`timescale 1ns/10ps

module cmd_sequencer (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 i_op_en,
    input  logic [cnn_cmd_pkg::CMD_CNT_W-1:0]    i_cmd_count,
    input  logic                                 i_fifo_empty,
    input  logic [cnn_cmd_pkg::CMD_WORD_W-1:0]   i_fifo_data,
    input  logic                                 i_engine_ready,
    output logic                                 o_fifo_rd_en,
    output logic                                 o_engine_valid,
    output logic                                 o_engine_reset,
    output logic                                 o_irq,
    output cnn_cmd_pkg::seq_state_e              o_state,
    output cnn_cmd_pkg::op_type_e                o_op_type,
    output logic [cnn_cmd_pkg::STRIDE_W-1:0]     o_stride,
    output logic [cnn_cmd_pkg::KERNEL_W-1:0]     o_kernel,
    output logic [cnn_cmd_pkg::SIDE_W-1:0]       o_i_side,
    output logic [cnn_cmd_pkg::SIDE_W-1:0]       o_o_side,
    output logic [cnn_cmd_pkg::CHAN_W-1:0]       o_i_channel,
    output logic [cnn_cmd_pkg::CHAN_W-1:0]       o_o_channel,
    output logic [cnn_cmd_pkg::MASK_W-1:0]       o_result_mask,
    output logic [cnn_cmd_pkg::KSIZE_W-1:0]      o_kernel_size,
    output logic [cnn_cmd_pkg::STRIDE2_W-1:0]    o_stride2,
    output logic [cnn_cmd_pkg::ADDR_W-1:0]       o_weight_start_addr,
    output logic [cnn_cmd_pkg::ADDR_W-1:0]       o_data_start_addr,
    output logic [cnn_cmd_pkg::ADDR_W-1:0]       o_p0_result_start_addr,
    output logic [cnn_cmd_pkg::ADDR_W-1:0]       o_p1_result_start_addr,
    output logic [cnn_cmd_pkg::PAD_W-1:0]        o_p0_padding_head,
    output logic [cnn_cmd_pkg::PAD_W-1:0]        o_p0_padding_body,
    output logic [cnn_cmd_pkg::PAD_W-1:0]        o_p1_padding_head,
    output logic [cnn_cmd_pkg::PAD_W-1:0]        o_p1_padding_body
);

    import cnn_cmd_pkg::*;

    seq_state_e            state;
    seq_state_e            state_nxt;
    // Position of the next popped word inside its command
    logic [WORD_IDX_W-1:0] word_idx;
    // Commands completed in this run
    logic [CMD_CNT_W-1:0]  done_cnt;
    logic [CMD_CNT_W-1:0]  done_nxt;
    logic                  last_word;
    logic                  last_cmd;

    // Pop whenever a word is waiting during collection
    assign o_fifo_rd_en = (state == ST_CMD_GET) && !i_fifo_empty;
    assign last_word    = (word_idx == WORD_IDX_W'(CMD_WORDS - 1));
    assign done_nxt     = done_cnt + 1'b1;
    assign last_cmd     = (done_nxt == i_cmd_count);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (i_op_en) begin
                    state_nxt = ST_CMD_GET;
                end
            end
            ST_CMD_GET: begin
                // Eighth word completes the command
                if (o_fifo_rd_en && last_word) begin
                    state_nxt = ST_CMD_ISSUE;
                end
            end
            ST_CMD_ISSUE: begin
                state_nxt = ST_OP_RUN;
            end
            ST_OP_RUN: begin
                if (i_engine_ready) begin
                    state_nxt = last_cmd ? ST_FINISH : ST_CMD_GET;
                end
            end
            ST_FINISH: begin
                // Hold irq until the host drops the run
                if (!i_op_en) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= ST_IDLE;
            word_idx       <= '0;
            done_cnt       <= '0;
            o_engine_valid <= 1'b0;
            o_engine_reset <= 1'b1;
        end else begin
            state <= state_nxt;
            case (state)
                ST_IDLE: begin
                    word_idx <= '0;
                    done_cnt <= '0;
                end
                ST_CMD_GET: begin
                    if (o_fifo_rd_en) begin
                        word_idx <= last_word ? '0 : word_idx + 1'b1;
                    end
                    // Release the engine as the command goes to issue
                    if (o_fifo_rd_en && last_word) begin
                        o_engine_reset <= 1'b0;
                    end
                end
                ST_CMD_ISSUE: begin
                    o_engine_valid <= 1'b1;
                end
                ST_OP_RUN: begin
                    // Ready pulse closes the command
                    if (i_engine_ready) begin
                        o_engine_valid <= 1'b0;
                        o_engine_reset <= 1'b1;
                        done_cnt       <= done_nxt;
                    end
                end
                default: begin
                    o_engine_valid <= 1'b0;
                end
            endcase
        end
    end

    // Field unpack, one word per pop
    always_ff @(posedge clk) begin
        if (o_fifo_rd_en) begin
            case (word_idx)
                0: begin
                    o_op_type <= op_type_e'(i_fifo_data[2:0]);
                    o_stride  <= i_fifo_data[7:4];
                    o_kernel  <= i_fifo_data[15:8];
                    o_i_side  <= i_fifo_data[23:16];
                    o_o_side  <= i_fifo_data[31:24];
                end
                1: begin
                    o_i_channel <= i_fifo_data[15:0];
                    o_o_channel <= i_fifo_data[31:16];
                end
                2: begin
                    o_result_mask <= i_fifo_data[1:0];
                    o_kernel_size <= i_fifo_data[15:8];
                    o_stride2     <= i_fifo_data[31:16];
                end
                3: o_weight_start_addr    <= i_fifo_data[ADDR_W-1:0];
                4: o_data_start_addr      <= i_fifo_data[ADDR_W-1:0];
                5: o_p0_result_start_addr <= i_fifo_data[ADDR_W-1:0];
                6: o_p1_result_start_addr <= i_fifo_data[ADDR_W-1:0];
                default: begin
                    // Padding bytes low to high
                    o_p0_padding_head <= i_fifo_data[7:0];
                    o_p0_padding_body <= i_fifo_data[15:8];
                    o_p1_padding_head <= i_fifo_data[23:16];
                    o_p1_padding_body <= i_fifo_data[31:24];
                end
            endcase
        end
    end

    assign o_state = state;
    assign o_irq   = (state == ST_FINISH);

    // Word 0 of each command must carry a known operation
    a_op_legal: assert property (
        @(posedge clk) disable iff (rst)
        (state == ST_CMD_ISSUE) |->
            (o_op_type inside {OP_IDLE, OP_CONV_RELU, OP_MAX_POOL, OP_AVG_POOL})
    );

    // Valid must already be down once the last ready is taken
    a_no_valid_in_finish: assert property (
        @(posedge clk) disable iff (rst)
        (state == ST_FINISH) |-> !o_engine_valid
    );

endmodule

//--- design/cnn_cmd_pkg.sv
package cnn_cmd_pkg;

    // Layer operation held in bits 2:0 of command word 0
    typedef enum logic [2:0] {
        OP_IDLE      = 3'b000,
        OP_CONV_RELU = 3'b001,
        OP_MAX_POOL  = 3'b100,
        OP_AVG_POOL  = 3'b101
    } op_type_e;

    // Sequencer FSM states
    typedef enum logic [2:0] {
        // Waiting for a run to start
        ST_IDLE      = 3'd0,
        // Popping the eight words of one command
        ST_CMD_GET   = 3'd1,
        // One cycle to raise the engine valid
        ST_CMD_ISSUE = 3'd2,
        // Engine busy, waiting for its ready pulse
        ST_OP_RUN    = 3'd3,
        // All commands done, irq held
        ST_FINISH    = 3'd4
    } seq_state_e;

    // 256-bit command split into 32-bit words
    localparam int CMD_WORDS  = 8;
    localparam int CMD_WORD_W = 32;

    // Word index inside one command
    localparam int WORD_IDX_W = $clog2(CMD_WORDS);

    // Memory addresses carried in command words 3 to 6
    localparam int ADDR_W = 30;

    // Number of commands in one run
    localparam int CMD_CNT_W = 7;

    // Number of words in one run
    localparam int WORD_CNT_W = CMD_CNT_W + WORD_IDX_W;

    // Layer field widths
    localparam int STRIDE_W  = 4;
    localparam int KERNEL_W  = 8;
    localparam int SIDE_W    = 8;
    localparam int CHAN_W    = 16;
    localparam int MASK_W    = 2;
    localparam int KSIZE_W   = 8;
    localparam int STRIDE2_W = 16;

    // Four padding bytes packed in word 7
    localparam int PAD_W = 8;

endpackage

//--- design/cnn_cmd_top.sv
`timescale 1ns/10ps

module cnn_cmd_top #(
    parameter int FIFO_DEPTH = 8,
    parameter int MEM_ADDR_W = 8
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 i_op_en,
    input  logic [cnn_cmd_pkg::CMD_CNT_W-1:0]    i_cmd_count,
    // Command memory
    output logic                                 o_mem_rd_en,
    output logic [MEM_ADDR_W-1:0]                o_mem_addr,
    input  logic [cnn_cmd_pkg::CMD_WORD_W-1:0]   i_mem_rd_data,
    // Compute engine
    input  logic                                 i_engine_ready,
    output logic                                 o_engine_valid,
    output logic                                 o_engine_reset,
    output logic                                 o_irq,
    output cnn_cmd_pkg::seq_state_e              o_state,
    output cnn_cmd_pkg::op_type_e                o_op_type,
    output logic [cnn_cmd_pkg::STRIDE_W-1:0]     o_stride,
    output logic [cnn_cmd_pkg::KERNEL_W-1:0]     o_kernel,
    output logic [cnn_cmd_pkg::SIDE_W-1:0]       o_i_side,
    output logic [cnn_cmd_pkg::SIDE_W-1:0]       o_o_side,
    output logic [cnn_cmd_pkg::CHAN_W-1:0]       o_i_channel,
    output logic [cnn_cmd_pkg::CHAN_W-1:0]       o_o_channel,
    output logic [cnn_cmd_pkg::MASK_W-1:0]       o_result_mask,
    output logic [cnn_cmd_pkg::KSIZE_W-1:0]      o_kernel_size,
    output logic [cnn_cmd_pkg::STRIDE2_W-1:0]    o_stride2,
    output logic [cnn_cmd_pkg::ADDR_W-1:0]       o_weight_start_addr,
    output logic [cnn_cmd_pkg::ADDR_W-1:0]       o_data_start_addr,
    output logic [cnn_cmd_pkg::ADDR_W-1:0]       o_p0_result_start_addr,
    output logic [cnn_cmd_pkg::ADDR_W-1:0]       o_p1_result_start_addr,
    output logic [cnn_cmd_pkg::PAD_W-1:0]        o_p0_padding_head,
    output logic [cnn_cmd_pkg::PAD_W-1:0]        o_p0_padding_body,
    output logic [cnn_cmd_pkg::PAD_W-1:0]        o_p1_padding_head,
    output logic [cnn_cmd_pkg::PAD_W-1:0]        o_p1_padding_body
);

    import cnn_cmd_pkg::*;

    // Loader to FIFO
    logic                  fifo_wr_en;
    logic [CMD_WORD_W-1:0] fifo_wr_data;
    logic                  fifo_full;
    // FIFO to sequencer
    logic                  fifo_rd_en;
    logic [CMD_WORD_W-1:0] fifo_rd_data;
    logic                  fifo_empty;

    // Producer side, fetches command words from memory
    cmd_loader #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) u_loader (
        .clk            (clk),
        .rst            (rst),
        .i_op_en        (i_op_en),
        .i_cmd_count    (i_cmd_count),
        .i_fifo_full    (fifo_full),
        .i_mem_rd_data  (i_mem_rd_data),
        .o_mem_rd_en    (o_mem_rd_en),
        .o_mem_addr     (o_mem_addr),
        .o_fifo_wr_en   (fifo_wr_en),
        .o_fifo_wr_data (fifo_wr_data)
    );

    cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .i_wr_en   (fifo_wr_en),
        .i_wr_data (fifo_wr_data),
        .i_rd_en   (fifo_rd_en),
        .o_rd_data (fifo_rd_data),
        .o_full    (fifo_full),
        .o_empty   (fifo_empty)
    );

    // Consumer side, decodes and hands commands to the engine
    cmd_sequencer u_seq (
        .clk                    (clk),
        .rst                    (rst),
        .i_op_en                (i_op_en),
        .i_cmd_count            (i_cmd_count),
        .i_fifo_empty           (fifo_empty),
        .i_fifo_data            (fifo_rd_data),
        .i_engine_ready         (i_engine_ready),
        .o_fifo_rd_en           (fifo_rd_en),
        .o_engine_valid         (o_engine_valid),
        .o_engine_reset         (o_engine_reset),
        .o_irq                  (o_irq),
        .o_state                (o_state),
        .o_op_type              (o_op_type),
        .o_stride               (o_stride),
        .o_kernel               (o_kernel),
        .o_i_side               (o_i_side),
        .o_o_side               (o_o_side),
        .o_i_channel            (o_i_channel),
        .o_o_channel            (o_o_channel),
        .o_result_mask          (o_result_mask),
        .o_kernel_size          (o_kernel_size),
        .o_stride2              (o_stride2),
        .o_weight_start_addr    (o_weight_start_addr),
        .o_data_start_addr      (o_data_start_addr),
        .o_p0_result_start_addr (o_p0_result_start_addr),
        .o_p1_result_start_addr (o_p1_result_start_addr),
        .o_p0_padding_head      (o_p0_padding_head),
        .o_p0_padding_body      (o_p0_padding_body),
        .o_p1_padding_head      (o_p1_padding_head),
        .o_p1_padding_body      (o_p1_padding_body)
    );

endmodule

//--- flist.f
+incdir+tests
design/cnn_cmd_pkg.sv
design/cmd_loader.sv
design/cmd_fifo.sv
design/cmd_sequencer.sv
design/cnn_cmd_top.sv
tests/cnn_cmd_tb.sv

//--- tests/cnn_cmd_cases.svh
`ifndef CNN_CMD_CASES_SVH
`define CNN_CMD_CASES_SVH

// Commands held in command memory, in run order
localparam int NUM_CMDS    = 4;
// Decoded fields checked per command
localparam int FIELD_COUNT = 18;

// Raw command words, word 0 first
// Junk sits in unused bits (word 0 bit 3, word 2 bits 7:2, address bits 31:30)
localparam logic [31:0] CMD_TBL [NUM_CMDS][CMD_WORDS] = '{
    '{32'h2022_0311, 32'h0040_0003, 32'h0002_0901, 32'hC000_1000,
      32'h0002_0000, 32'h0003_0000, 32'h0004_0000, 32'h0102_0304},
    '{32'h1020_0224, 32'h0040_0040, 32'h0004_FCFE, 32'h0005_0000,
      32'h4006_0000, 32'h0007_0000, 32'h0008_0000, 32'h0000_0100},
    '{32'h080A_031D, 32'h0100_0080, 32'hFFFF_0703, 32'h3FFF_FFFF,
      32'h8000_1234, 32'h0009_ABCD, 32'hFFFF_FFFF, 32'hA5C3_5A3C},
    '{32'hFF01_01F0, 32'hDEAD_BEEF, 32'h1234_8000, 32'h0000_0000,
      32'h0000_0001, 32'h2AAA_AAAA, 32'h1555_5555, 32'h7F80_FF00}
};

// Expected fields, columns in this order
//   op_type stride kernel i_side o_side i_channel o_channel result_mask kernel_size stride2
//   weight data p0_result p1_result p0_pad_head p0_pad_body p1_pad_head p1_pad_body
localparam logic [31:0] EXP_TBL [NUM_CMDS][FIELD_COUNT] = '{
    '{'h1, 'h1, 'h03, 'h22, 'h20, 'h0003, 'h0040, 'h1, 'h09, 'h0002,
      'h0000_1000, 'h0002_0000, 'h0003_0000, 'h0004_0000, 'h04, 'h03, 'h02, 'h01},
    '{'h4, 'h2, 'h02, 'h20, 'h10, 'h0040, 'h0040, 'h2, 'hFC, 'h0004,
      'h0005_0000, 'h0006_0000, 'h0007_0000, 'h0008_0000, 'h00, 'h01, 'h00, 'h00},
    '{'h5, 'h1, 'h03, 'h0A, 'h08, 'h0080, 'h0100, 'h3, 'h07, 'hFFFF,
      'h3FFF_FFFF, 'h0000_1234, 'h0009_ABCD, 'h3FFF_FFFF, 'h3C, 'h5A, 'hC3, 'hA5},
    '{'h0, 'hF, 'h01, 'h01, 'hFF, 'hBEEF, 'hDEAD, 'h0, 'h80, 'h1234,
      'h0000_0000, 'h0000_0001, 'h2AAA_AAAA, 'h1555_5555, 'h00, 'hFF, 'h80, 'h7F}
};

// One run per row: command count, shortest engine delay in cycles
// Run 0 keeps the engine slow so the FIFO backs up
localparam int NUM_RUNS = 3;
localparam int RUN_TBL [NUM_RUNS][2] = '{
    '{4, 14},
    '{2, 0},
    '{3, 5}
};

`endif

//--- tests/cnn_cmd_tb.sv
`timescale 1ns/10ps

module cnn_cmd_tb;

    import cnn_cmd_pkg::*;

    // Shallow FIFO so a slow engine stalls the loader
    localparam int FIFO_DEPTH = 4;
    localparam int MEM_ADDR_W = 8;
    localparam logic [31:0] SEED = 32'h3d9b5982;
    // Quiet cycles watched after the last command of a run
    localparam int IDLE_WAIT = 30;

    `include "cnn_cmd_cases.svh"

    logic                  clk;
    logic                  rst;
    logic                  op_en;
    logic [CMD_CNT_W-1:0]  cmd_count;
    logic                  mem_rd_en;
    logic [MEM_ADDR_W-1:0] mem_addr;
    logic [31:0]           mem_rd_data;
    logic                  engine_ready;
    logic                  engine_valid;
    logic                  engine_reset;
    logic                  irq;
    seq_state_e            state;
    op_type_e              op_type;
    logic [STRIDE_W-1:0]   stride;
    logic [KERNEL_W-1:0]   kernel;
    logic [SIDE_W-1:0]     i_side;
    logic [SIDE_W-1:0]     o_side;
    logic [CHAN_W-1:0]     i_channel;
    logic [CHAN_W-1:0]     o_channel;
    logic [MASK_W-1:0]     result_mask;
    logic [KSIZE_W-1:0]    kernel_size;
    logic [STRIDE2_W-1:0]  stride2;
    logic [ADDR_W-1:0]     weight_addr;
    logic [ADDR_W-1:0]     data_addr;
    logic [ADDR_W-1:0]     p0_addr;
    logic [ADDR_W-1:0]     p1_addr;
    logic [PAD_W-1:0]      p0_pad_head;
    logic [PAD_W-1:0]      p0_pad_body;
    logic [PAD_W-1:0]      p1_pad_head;
    logic [PAD_W-1:0]      p1_pad_body;

    // Command memory model
    logic [31:0]           cmd_mem [2**MEM_ADDR_W];
    logic                  rd_hit;
    logic [MEM_ADDR_W-1:0] rd_addr;

    int error_count = 0;
    int test_count = 0;
    int test_fail_count = 0;
    // Per-run bookkeeping
    int valid_rises = 0;
    int full_cycles = 0;
    int cur_count = 0;
    int delay_min = 0;
    logic valid_q = 1'b0;
    logic ready_q = 1'b0;

    cnn_cmd_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .MEM_ADDR_W (MEM_ADDR_W)
    ) u_dut (
        .clk                    (clk),
        .rst                    (rst),
        .i_op_en                (op_en),
        .i_cmd_count            (cmd_count),
        .o_mem_rd_en            (mem_rd_en),
        .o_mem_addr             (mem_addr),
        .i_mem_rd_data          (mem_rd_data),
        .i_engine_ready         (engine_ready),
        .o_engine_valid         (engine_valid),
        .o_engine_reset         (engine_reset),
        .o_irq                  (irq),
        .o_state                (state),
        .o_op_type              (op_type),
        .o_stride               (stride),
        .o_kernel               (kernel),
        .o_i_side               (i_side),
        .o_o_side               (o_side),
        .o_i_channel            (i_channel),
        .o_o_channel            (o_channel),
        .o_result_mask          (result_mask),
        .o_kernel_size          (kernel_size),
        .o_stride2              (stride2),
        .o_weight_start_addr    (weight_addr),
        .o_data_start_addr      (data_addr),
        .o_p0_result_start_addr (p0_addr),
        .o_p1_result_start_addr (p1_addr),
        .o_p0_padding_head      (p0_pad_head),
        .o_p0_padding_body      (p0_pad_body),
        .o_p1_padding_head      (p1_pad_head),
        .o_p1_padding_body      (p1_pad_body)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %0t ns: %s expected 'h%0h got 'h%0h", $time, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("test %s ok", name);
        end else begin
            test_fail_count++;
            $display("test %s had %0d mismatches", name, error_count - errs_before);
        end
    endtask

    // Decoded fields against one row of the expected table
    task automatic compare_fields(input int run, input int row);
        string tag;
        tag = $sformatf("run %0d cmd %0d", run, row);
        check_value({tag, " op_type"}, EXP_TBL[row][0], op_type);
        check_value({tag, " stride"}, EXP_TBL[row][1], stride);
        check_value({tag, " kernel"}, EXP_TBL[row][2], kernel);
        check_value({tag, " i_side"}, EXP_TBL[row][3], i_side);
        check_value({tag, " o_side"}, EXP_TBL[row][4], o_side);
        check_value({tag, " i_channel"}, EXP_TBL[row][5], i_channel);
        check_value({tag, " o_channel"}, EXP_TBL[row][6], o_channel);
        check_value({tag, " result_mask"}, EXP_TBL[row][7], result_mask);
        check_value({tag, " kernel_size"}, EXP_TBL[row][8], kernel_size);
        check_value({tag, " stride2"}, EXP_TBL[row][9], stride2);
        check_value({tag, " weight addr"}, EXP_TBL[row][10], weight_addr);
        check_value({tag, " data addr"}, EXP_TBL[row][11], data_addr);
        check_value({tag, " p0 result addr"}, EXP_TBL[row][12], p0_addr);
        check_value({tag, " p1 result addr"}, EXP_TBL[row][13], p1_addr);
        check_value({tag, " p0 pad head"}, EXP_TBL[row][14], p0_pad_head);
        check_value({tag, " p0 pad body"}, EXP_TBL[row][15], p0_pad_body);
        check_value({tag, " p1 pad head"}, EXP_TBL[row][16], p1_pad_head);
        check_value({tag, " p1 pad body"}, EXP_TBL[row][17], p1_pad_body);
    endtask

    // One host run: start, check every issued command, wait for irq, drop the run
    task automatic play_run(input int r);
        int errs_before;
        int count;
        count = RUN_TBL[r][0];
        @(posedge clk);
        #2;
        cur_count   = count;
        delay_min   = RUN_TBL[r][1];
        valid_rises = 0;
        full_cycles = 0;
        cmd_count   = CMD_CNT_W'(count);
        op_en       = 1'b1;
        errs_before = error_count;
        // Loader needs one edge to see the run
        @(negedge clk);
        check_value("read strobe before op_en seen", 0, mem_rd_en);
        @(negedge clk);
        check_value("first read one cycle after op_en", 1, mem_rd_en);
        check_value("first read address", 0, mem_addr);
        report_test($sformatf("run %0d start", r), errs_before);
        for (int c = 0; c < count; c++) begin
            errs_before = error_count;
            do @(negedge clk); while (!engine_valid);
            check_value("irq low while commands remain", 0, irq);
            check_value("state while engine busy", ST_OP_RUN, state);
            compare_fields(r, c);
            do @(negedge clk); while (engine_valid);
            report_test($sformatf("run %0d cmd %0d", r, c), errs_before);
        end
        errs_before = error_count;
        // Last ready moves the FSM to FINISH on the same edge that drops valid
        check_value("irq after last ready", 1, irq);
        check_value("state after last ready", ST_FINISH, state);
        repeat (IDLE_WAIT) begin
            @(negedge clk);
            check_value("no valid after last command", 0, engine_valid);
            check_value("irq held", 1, irq);
        end
        check_value("commands issued", count, valid_rises);
        if (delay_min >= 12) begin
            check_value("FIFO filled under slow engine", 1, full_cycles != 0);
        end
        @(posedge clk);
        #2 op_en = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_value("irq cleared by op_en low", 0, irq);
        check_value("state back to idle", ST_IDLE, state);
        check_value("no read after op_en low", 0, mem_rd_en);
        check_value("engine reset after run", 1, engine_reset);
        report_test($sformatf("run %0d end", r), errs_before);
    endtask

    // Memory answers one cycle after the read strobe
    always begin
        @(negedge clk);
        rd_hit  = mem_rd_en;
        rd_addr = mem_addr;
        if (rd_hit) begin
            check_value("read address in range", 1, rd_addr < cur_count * CMD_WORDS);
        end
        @(posedge clk);
        #2;
        if (rd_hit) begin
            mem_rd_data = cmd_mem[rd_addr];
        end
    end

    // Engine model, one ready pulse after a random delay
    initial begin : engine_model
        int unsigned delay;
        forever begin
            @(negedge clk);
            if (engine_valid) begin
                delay = delay_min + ($urandom % (21 - delay_min));
                repeat (delay) @(posedge clk);
                @(posedge clk);
                #2 engine_ready = 1'b1;
                @(posedge clk);
                #2 engine_ready = 1'b0;
            end
        end
    end

    // Valid/ready protocol and back-pressure monitor
    always @(negedge clk) begin
        if (rst) begin
            valid_q = 1'b0;
            ready_q = 1'b0;
        end else begin
            if (engine_valid) begin
                check_value("engine reset low while valid", 0, engine_reset);
            end
            // Valid drops exactly after the ready edge
            if (valid_q) begin
                check_value("valid held until ready", !ready_q, engine_valid);
            end
            if (engine_valid && !valid_q) begin
                valid_rises++;
            end
            if (u_dut.fifo_full) begin
                full_cycles++;
            end
            valid_q = engine_valid;
            ready_q = engine_ready;
        end
    end

    initial begin : watchdog
        int unsigned limit;
        limit = 16;
        for (int r = 0; r < NUM_RUNS; r++) begin
            limit += RUN_TBL[r][0] * CMD_WORDS * 3 + RUN_TBL[r][0] * 25 + 200;
        end
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Test failures found");
        $finish;
    end

    initial begin : main
        int errs_before;
        void'($urandom(SEED));
        rst          = 1'b1;
        op_en        = 1'b0;
        cmd_count    = '0;
        mem_rd_data  = '0;
        engine_ready = 1'b0;
        // Table words first, then a pattern tied to every address bit
        for (int a = 0; a < 2**MEM_ADDR_W; a++) begin
            if (a < NUM_CMDS * CMD_WORDS) begin
                cmd_mem[a] = CMD_TBL[a / CMD_WORDS][a % CMD_WORDS];
            end else begin
                cmd_mem[a] = 32'hBAD0_0000 | a;
            end
        end
        repeat (16) @(posedge clk);
        #2 rst = 1'b0;
        @(negedge clk);
        errs_before = error_count;
        check_value("valid after reset", 0, engine_valid);
        check_value("irq after reset", 0, irq);
        check_value("read strobe after reset", 0, mem_rd_en);
        check_value("engine reset after reset", 1, engine_reset);
        check_value("state after reset", ST_IDLE, state);
        report_test("reset state", errs_before);
        for (int r = 0; r < NUM_RUNS; r++) begin
            play_run(r);
        end
        $display("Summary: %0d tests, %0d with mismatches, %0d mismatches in total",
                 test_count, test_fail_count, error_count);
        if (error_count == 0 && test_fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
